// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = d_mem_tb
FILELIST  = list.f
SIM_EXE   = obj_dir/$(TOP)_sim

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	out="$$(./$(SIM_EXE))"; echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

// ==== d_mem.sv ====
`timescale 1ns/1ps

module d_mem (
    input  logic     clock,
    input  logic     arst_n,
    dmem_port_if.mem port_a,
    dmem_port_if.mem port_b
);
    import dmem_pkg::*;

    // Storage, one word per entry split into byte lanes
    logic [BE_W-1:0][7:0] mem_array [DMEM_WORDS];

    // ----------------------------------------------------------
    // Write path
    // ----------------------------------------------------------

    // Port a first, then port b
    // Last nonblocking write to a lane wins, so port b owns collisions
    always_ff @(posedge clock) begin
        if (port_a.wren) begin
            for (int i = 0; i < BE_W; i++) begin
                if (port_a.byteena[i]) begin
                    mem_array[port_a.addr][i] <= port_a.wdata[8*i +: 8];
                end
            end
        end
        if (port_b.wren) begin
            for (int i = 0; i < BE_W; i++) begin
                if (port_b.byteena[i]) begin
                    mem_array[port_b.addr][i] <= port_b.wdata[8*i +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Read path
    // ----------------------------------------------------------

    // Synchronous read on both ports
    // Samples the array before this edge's writes land, so old data
    // comes back on a same-cycle read/write to one word
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            port_a.q <= '0;
            port_b.q <= '0;
        end else begin
            port_a.q <= mem_array[port_a.addr];
            port_b.q <= mem_array[port_b.addr];
        end
    end

endmodule

// ==== d_mem_assert.sv ====
`timescale 1ns/1ps

module d_mem_assert (
    input logic                 clock,
    input logic                 arst_n,
    input logic                 load_en,
    input logic                 load_valid,
    input logic                 fill_busy,
    input logic                 fill_done,
    input logic                 host_en,
    input dmem_pkg::word_addr_t fill_addr
);

    // Load result only one cycle after a load request
    a_load_valid: assert property (@(posedge clock) disable iff (!arst_n)
        load_valid |-> $past(load_en))
        else $error("load_valid without a load one cycle earlier");

    // Done comes with busy already dropped
    a_done_not_busy: assert property (@(posedge clock) disable iff (!arst_n)
        fill_done |-> !fill_busy)
        else $error("fill_done high while fill_busy high");

    // A host cycle during a fill freezes the fill engine in place
    a_host_stalls_fill: assert property (@(posedge clock) disable iff (!arst_n)
        (fill_busy && host_en) |=> (fill_busy && $stable(fill_addr)))
        else $error("fill engine moved while the host owned port b");

endmodule

bind d_mem_subsys d_mem_assert u_assert (
    .clock      (clock),
    .arst_n     (arst_n),
    .load_en    (load_en),
    .load_valid (load_valid),
    .fill_busy  (fill_busy),
    .fill_done  (fill_done),
    .host_en    (host_en),
    .fill_addr  (fill_addr)
);

// ==== d_mem_cases.txt ====
# op addr size_or_be data expected (all hex)
# op 1 st, 2 ld signed, 3 ld unsigned, 4 host wr, 5 host rd, 6 fill, 7 collide, 8 two loads, 9 fill+host
1 010 2 deadbeef 0
2 010 2 0 deadbeef
1 020 2 11223344 0
1 021 0 000000a5 0
2 020 2 0 1122a544
2 021 0 0 ffffffa5
3 021 0 0 000000a5
1 022 1 0000c3d2 0
2 022 1 0 ffffc3d2
3 022 1 0 0000c3d2
2 020 1 0 ffffa544
4 030 f cafef00d 0
2 0c0 2 0 cafef00d
5 004 0 0 deadbeef
4 030 c 12340000 0
5 030 0 0 1234f00d
4 0ff f 0badc0de 0
4 108 f 12345678 0
6 100 8 a5a5a5a5 0
5 0ff 0 0 0badc0de
5 100 0 0 a5a5a5a5
5 107 0 0 a5a5a5a5
5 108 0 0 12345678
9 200 8 5a5a5a5a 77777777
5 200 0 0 77777777
5 201 0 0 5a5a5a5a
5 207 0 0 5a5a5a5a
8 010 020 deadbeef c3d2a544
7 040 f 99999999 11111111
5 040 0 0 99999999
7 041 3 0000abcd 11111111
5 041 0 0 1111abcd

// ==== d_mem_checker.sv ====
`timescale 1ns/1ps

module d_mem_checker (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            load_valid,
    input  dmem_pkg::data_t load_data,
    input  logic            host_rvalid,
    input  dmem_pkg::data_t host_rdata,
    input  logic            fill_busy,
    input  logic            fill_done
);
    import dmem_pkg::*;

    // Expected result, owning case and the cycle it must show up in
    typedef struct packed {
        logic [31:0] value;
        logic [31:0] case_id;
        logic [31:0] due;
    } expect_t;

    expect_t lsu_q  [$];
    expect_t host_q [$];
    // Running fills, due is the first cycle busy must be seen
    expect_t fill_q [$];
    int      errs        = 0;
    int      cycle_count = 0;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // ----------------------------------------------------------
    // Expectations from the stimulus side
    // ----------------------------------------------------------

    // Called on the drive edge, result due one count later
    task automatic expect_load(input logic [31:0] value, input int case_id);
        lsu_q.push_back({value, 32'(case_id), 32'(cycle_count + 1)});
    endtask

    task automatic expect_host(input logic [31:0] value, input int case_id);
        host_q.push_back({value, 32'(case_id), 32'(cycle_count + 1)});
    endtask

    // Busy rises on the edge after the start pulse
    task automatic expect_fill(input int case_id);
        fill_q.push_back({32'h0, 32'(case_id), 32'(cycle_count + 1)});
    endtask

    function automatic int pending_count();
        return lsu_q.size() + host_q.size() + fill_q.size();
    endfunction

    function automatic int error_total();
        return errs;
    endfunction

    task automatic drop_pending();
        lsu_q.delete();
        host_q.delete();
        fill_q.delete();
    endtask

    // ----------------------------------------------------------
    // Compare, sampled mid-cycle
    // ----------------------------------------------------------
    always @(negedge clock) begin
        expect_t e;
        if (arst_n) begin
            if (load_valid) begin
                if (lsu_q.size() == 0) begin
                    $display("%0t: load_valid arrived with no load outstanding", $time);
                    errs++;
                end else begin
                    e = lsu_q[0];
                    if (load_data !== e.value) begin
                        $display("ERR %0t case %0d load data got %h expected %h",
                                 $time, e.case_id, load_data, e.value);
                        errs++;
                    end
                    if (32'(cycle_count) != e.due) begin
                        $display("ERR %0t case %0d load returned at cycle %0d expected %0d",
                                 $time, e.case_id, cycle_count, e.due);
                        errs++;
                    end
                    void'(lsu_q.pop_front());
                end
            end
            if (host_rvalid) begin
                if (host_q.size() == 0) begin
                    $display("%0t: host_rvalid arrived with no host read outstanding", $time);
                    errs++;
                end else begin
                    e = host_q[0];
                    if (host_rdata !== e.value) begin
                        $display("ERR %0t case %0d host data got %h expected %h",
                                 $time, e.case_id, host_rdata, e.value);
                        errs++;
                    end
                    if (32'(cycle_count) != e.due) begin
                        $display("ERR %0t case %0d host read at cycle %0d expected %0d",
                                 $time, e.case_id, cycle_count, e.due);
                        errs++;
                    end
                    void'(host_q.pop_front());
                end
            end
            // Busy level, low when idle and high until the done cycle
            if (fill_q.size() == 0) begin
                if (fill_busy !== 1'b0) begin
                    $display("%0t: fill_busy high with no fill running", $time);
                    errs++;
                end
            end else if (32'(cycle_count) >= fill_q[0].due && !fill_done) begin
                e = fill_q[0];
                if (fill_busy !== 1'b1) begin
                    $display("ERR %0t case %0d fill_busy got %b expected 1",
                             $time, e.case_id, fill_busy);
                    errs++;
                end
            end
            if (fill_done) begin
                if (fill_q.size() == 0) begin
                    $display("%0t: fill_done pulsed with no fill running", $time);
                    errs++;
                end else begin
                    e = fill_q[0];
                    // Busy falls on the same edge that raises done
                    if (fill_busy !== 1'b0) begin
                        $display("ERR %0t case %0d fill_busy got %b expected 0 with done",
                                 $time, e.case_id, fill_busy);
                        errs++;
                    end
                    void'(fill_q.pop_front());
                end
            end
        end
    end

endmodule

// ==== d_mem_subsys.sv ====
`timescale 1ns/1ps

module d_mem_subsys (
    input  logic                   clock,
    input  logic                   arst_n,
    // Load/store path
    input  logic                   load_en,
    input  logic                   store_en,
    input  dmem_pkg::byte_addr_t   lsu_addr,
    input  dmem_pkg::access_size_e lsu_size,
    input  logic                   load_unsigned,
    input  dmem_pkg::data_t        store_data,
    output dmem_pkg::data_t        load_data,
    output logic                   load_valid,
    // Host word port
    input  logic                   host_en,
    input  logic                   host_wren,
    input  dmem_pkg::word_addr_t   host_addr,
    input  dmem_pkg::data_t        host_wdata,
    input  dmem_pkg::be_t          host_byteena,
    output dmem_pkg::data_t        host_rdata,
    output logic                   host_rvalid,
    // Fill control
    input  logic                   fill_start,
    input  dmem_pkg::word_addr_t   fill_base,
    input  dmem_pkg::word_addr_t   fill_count,
    input  dmem_pkg::data_t        fill_pattern,
    output logic                   fill_busy,
    output logic                   fill_done
);
    import dmem_pkg::*;

    // Fill engine to arbiter
    word_addr_t fill_addr;
    data_t      fill_data;
    logic       fill_wren;
    logic       hold;

    // ----------------------------------------------------------
    // Memory ports
    // ----------------------------------------------------------
    dmem_port_if port_a_bus ();
    dmem_port_if port_b_bus ();

    // Port a, core load/store
    lsu_access u_lsu_access (
        .clock         (clock),
        .arst_n        (arst_n),
        .load_en       (load_en),
        .store_en      (store_en),
        .addr          (lsu_addr),
        .size          (lsu_size),
        .load_unsigned (load_unsigned),
        .store_data    (store_data),
        .load_data     (load_data),
        .load_valid    (load_valid),
        .mem           (port_a_bus.master)
    );

    fill_engine u_fill_engine (
        .clock        (clock),
        .arst_n       (arst_n),
        .fill_start   (fill_start),
        .fill_base    (fill_base),
        .fill_count   (fill_count),
        .fill_pattern (fill_pattern),
        .hold         (hold),
        .fill_busy    (fill_busy),
        .fill_done    (fill_done),
        .wr_addr      (fill_addr),
        .wr_data      (fill_data),
        .wr_en        (fill_wren)
    );

    // Port b, host over fill
    port_b_arbiter u_port_b_arbiter (
        .clock        (clock),
        .arst_n       (arst_n),
        .host_en      (host_en),
        .host_wren    (host_wren),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_byteena (host_byteena),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .fill_wren    (fill_wren),
        .hold         (hold),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid),
        .mem          (port_b_bus.master)
    );

    d_mem u_d_mem (
        .clock  (clock),
        .arst_n (arst_n),
        .port_a (port_a_bus.mem),
        .port_b (port_b_bus.mem)
    );

endmodule

// ==== d_mem_tb.sv ====
`timescale 1ns/1ps

module d_mem_tb;
    import dmem_pkg::*;

    localparam int CYCLES_PER_CASE = 64;
    localparam int RESET_CYCLES    = 16;

    logic         clock = 1'b0;
    logic         arst_n;
    logic         load_en;
    logic         store_en;
    byte_addr_t   lsu_addr;
    access_size_e lsu_size;
    logic         load_unsigned;
    data_t        store_data;
    data_t        load_data;
    logic         load_valid;
    logic         host_en;
    logic         host_wren;
    word_addr_t   host_addr;
    data_t        host_wdata;
    be_t          host_byteena;
    data_t        host_rdata;
    logic         host_rvalid;
    logic         fill_start;
    word_addr_t   fill_base;
    word_addr_t   fill_count;
    data_t        fill_pattern;
    logic         fill_busy;
    logic         fill_done;

    // One entry per case line
    logic [31:0] case_op [$];
    logic [31:0] case_a  [$];
    logic [31:0] case_b  [$];
    logic [31:0] case_c  [$];
    logic [31:0] case_d  [$];
    bit          cases_loaded = 1'b0;
    int          pass_count   = 0;
    int          fail_count   = 0;

    always #5 clock = ~clock;

    d_mem_subsys u_dut (
        .clock (clock), .arst_n (arst_n),
        .load_en (load_en), .store_en (store_en), .lsu_addr (lsu_addr),
        .lsu_size (lsu_size), .load_unsigned (load_unsigned),
        .store_data (store_data), .load_data (load_data), .load_valid (load_valid),
        .host_en (host_en), .host_wren (host_wren), .host_addr (host_addr),
        .host_wdata (host_wdata), .host_byteena (host_byteena),
        .host_rdata (host_rdata), .host_rvalid (host_rvalid),
        .fill_start (fill_start), .fill_base (fill_base), .fill_count (fill_count),
        .fill_pattern (fill_pattern), .fill_busy (fill_busy), .fill_done (fill_done)
    );

    d_mem_checker u_checker (
        .clock (clock), .arst_n (arst_n),
        .load_valid (load_valid), .load_data (load_data),
        .host_rvalid (host_rvalid), .host_rdata (host_rdata),
        .fill_busy (fill_busy), .fill_done (fill_done)
    );

    // ----------------------------------------------------------
    // Case file and drive helpers
    // ----------------------------------------------------------
    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f0, f1, f2, f3, f4;
        fd = $fopen("d_mem_cases.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blanks and column notes
            if (line.len() < 2 || line[0] == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            if (n == 5) begin
                case_op.push_back(f0);
                case_a.push_back(f1);
                case_b.push_back(f2);
                case_c.push_back(f3);
                case_d.push_back(f4);
            end
        end
        $fclose(fd);
    endtask

    task automatic lsu_store(input logic [31:0] a, input logic [31:0] sz, input logic [31:0] d);
        store_en   = 1'b1;
        lsu_addr   = a[DMEM_AW+1:0];
        lsu_size   = access_size_e'(sz[1:0]);
        store_data = d;
        @(negedge clock);
        store_en = 1'b0;
    endtask

    // Issue one load, caller ends the strobe
    task automatic lsu_load_issue(input logic [31:0] a, input logic [31:0] sz,
                                  input logic uns, input logic [31:0] exp, input int id);
        load_en       = 1'b1;
        lsu_addr      = a[DMEM_AW+1:0];
        lsu_size      = access_size_e'(sz[1:0]);
        load_unsigned = uns;
        u_checker.expect_load(exp, id);
        @(negedge clock);
    endtask

    task automatic host_write(input logic [31:0] a, input logic [31:0] be, input logic [31:0] d);
        host_en      = 1'b1;
        host_wren    = 1'b1;
        host_addr    = a[DMEM_AW-1:0];
        host_byteena = be[BE_W-1:0];
        host_wdata   = d;
        @(negedge clock);
        host_en   = 1'b0;
        host_wren = 1'b0;
    endtask

    task automatic host_read(input logic [31:0] a, input logic [31:0] exp, input int id);
        host_en   = 1'b1;
        host_wren = 1'b0;
        host_addr = a[DMEM_AW-1:0];
        u_checker.expect_host(exp, id);
        @(negedge clock);
        host_en = 1'b0;
    endtask

    task automatic start_fill(input logic [31:0] base, input logic [31:0] cnt,
                              input logic [31:0] pat, input int id);
        fill_start   = 1'b1;
        fill_base    = base[DMEM_AW-1:0];
        fill_count   = cnt[DMEM_AW-1:0];
        fill_pattern = pat;
        u_checker.expect_fill(id);
        @(negedge clock);
        fill_start = 1'b0;
    endtask

    task automatic run_case(input int i, output bit op_ok);
        op_ok = 1'b1;
        case (case_op[i])
            1: lsu_store(case_a[i], case_b[i], case_c[i]);
            2, 3: begin
                lsu_load_issue(case_a[i], case_b[i], case_op[i] == 3, case_d[i], i);
                load_en = 1'b0;
            end
            4: host_write(case_a[i], case_b[i], case_c[i]);
            5: host_read(case_a[i], case_d[i], i);
            6: start_fill(case_a[i], case_b[i], case_c[i], i);
            7: begin
                // LSU word store and host write hit one word on one edge
                store_en     = 1'b1;
                lsu_addr     = byte_addr_t'(case_a[i] << 2);
                lsu_size     = SIZE_WORD;
                store_data   = case_d[i];
                host_write(case_a[i], case_b[i], case_c[i]);
                store_en = 1'b0;
            end
            8: begin
                lsu_load_issue(case_a[i], 2, 1'b0, case_c[i], i);
                lsu_load_issue(case_b[i], 2, 1'b0, case_d[i], i);
                load_en = 1'b0;
            end
            9: begin
                // Host traffic lands after the fill passed the base word
                start_fill(case_a[i], case_b[i], case_c[i], i);
                repeat (2) @(negedge clock);
                host_write(case_a[i], 32'hf, case_d[i]);
                host_read(case_a[i], case_d[i], i);
            end
            default: begin
                $display("case %0d has unknown op %h", i, case_op[i]);
                op_ok = 1'b0;
            end
        endcase
    endtask

    // Wait for every outstanding result of the case
    task automatic wait_idle(input int i, output bit ok);
        int n;
        ok = 1'b1;
        n  = 0;
        while (u_checker.pending_count() != 0 && n < CYCLES_PER_CASE) begin
            @(negedge clock);
            n++;
        end
        if (u_checker.pending_count() != 0) begin
            $display("case %0d: an expected result did not arrive within %0d cycles",
                     i, CYCLES_PER_CASE);
            u_checker.drop_pending();
            ok = 1'b0;
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int errs_before;
        bit ok;
        bit op_ok;
        arst_n        = 1'b0;
        load_en       = 1'b0;
        store_en      = 1'b0;
        lsu_addr      = '0;
        lsu_size      = SIZE_WORD;
        load_unsigned = 1'b0;
        store_data    = '0;
        host_en       = 1'b0;
        host_wren     = 1'b0;
        host_addr     = '0;
        host_wdata    = '0;
        host_byteena  = '0;
        fill_start    = 1'b0;
        fill_base     = '0;
        fill_count    = '0;
        fill_pattern  = '0;
        read_cases();
        if (case_op.size() == 0) begin
            $display("no cases could be read from d_mem_cases.txt");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cases_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            arst_n = 1'b1;
            @(negedge clock);
            for (int i = 0; i < case_op.size(); i++) begin
                errs_before = u_checker.error_total();
                run_case(i, op_ok);
                wait_idle(i, ok);
                if (op_ok && ok && u_checker.error_total() == errs_before) begin
                    pass_count++;
                    $display("case %0d op %0h passed", i, case_op[i]);
                end else begin
                    fail_count++;
                    $display("case %0d op %0h failed", i, case_op[i]);
                end
            end
            $display("cases passed %0d failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    // Watchdog scaled by the number of cases
    initial begin
        wait (cases_loaded);
        #((case_op.size() * CYCLES_PER_CASE + RESET_CYCLES + 8) * 10);
        $display("watchdog expired before all cases finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== dmem_pkg.sv ====
package dmem_pkg;

    // ----------------------------------------------------------
    // Memory geometry
    // ----------------------------------------------------------

    // Data memory depth in 32-bit words
    localparam int DMEM_WORDS = 1024;
    // Word address width, 1024 words
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    // Core data width
    localparam int XLEN       = 32;
    // One enable per byte lane
    localparam int BE_W       = XLEN / 8;

    // ----------------------------------------------------------
    // Port record types
    // ----------------------------------------------------------

    // Word address as seen by the memory ports
    typedef logic [DMEM_AW-1:0] word_addr_t;
    // Byte address from the load/store path, two offset bits below the word
    typedef logic [DMEM_AW+1:0] byte_addr_t;

    // Data word and byte enables
    typedef logic [XLEN-1:0]    data_t;
    typedef logic [BE_W-1:0]    be_t;

    // Access sizes
    // Same as funct3[1:0] of RISC-V loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

endpackage

// ==== dmem_port_if.sv ====
`timescale 1ns/1ps

interface dmem_port_if;
    import dmem_pkg::*;

    // Word address of the access
    word_addr_t addr;
    // Write data, byte lane i in bits [8*i+7:8*i]
    data_t      wdata;
    // Lane enables, only looked at on writes
    be_t        byteena;
    // Write strobe, low means read
    logic       wren;
    // Registered read result
    data_t      q;

    // Side that issues accesses
    modport master (
        output addr,
        output wdata,
        output byteena,
        output wren,
        input  q
    );

    // Memory side
    modport mem (
        input  addr,
        input  wdata,
        input  byteena,
        input  wren,
        output q
    );

endinterface

// ==== fill_engine.sv ====
`timescale 1ns/1ps

module fill_engine (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 fill_start,
    input  dmem_pkg::word_addr_t fill_base,
    input  dmem_pkg::word_addr_t fill_count,
    input  dmem_pkg::data_t      fill_pattern,
    input  logic                 hold,
    output logic                 fill_busy,
    output logic                 fill_done,
    output dmem_pkg::word_addr_t wr_addr,
    output dmem_pkg::data_t      wr_data,
    output logic                 wr_en
);
    import dmem_pkg::*;

    // Words still to write, including the current one
    word_addr_t words_left;
    logic       last_word;

    assign last_word = (words_left == word_addr_t'(1));

    // Strobe stays up for the whole fill
    // Arbiter drops it while the host has the port
    assign wr_en = fill_busy;

    // ----------------------------------------------------------
    // Fill control
    // ----------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fill_busy  <= 1'b0;
            fill_done  <= 1'b0;
            wr_addr    <= '0;
            words_left <= '0;
        end else begin
            // Done is a single-cycle pulse
            fill_done <= 1'b0;
            if (!fill_busy) begin
                // Start only from idle, a start while busy is dropped
                if (fill_start) begin
                    fill_busy  <= 1'b1;
                    wr_addr    <= fill_base;
                    words_left <= fill_count;
                end
            end else if (!hold) begin
                // Current word goes to memory on this edge
                if (last_word) begin
                    fill_busy <= 1'b0;
                    fill_done <= 1'b1;
                end else begin
                    wr_addr    <= wr_addr + 1'b1;
                    words_left <= words_left - 1'b1;
                end
            end
        end
    end

    // Pattern captured at start
    always_ff @(posedge clock) begin
        if (fill_start && !fill_busy) begin
            wr_data <= fill_pattern;
        end
    end

endmodule

// ==== list.f ====
dmem_pkg.sv
dmem_port_if.sv
d_mem.sv
lsu_access.sv
fill_engine.sv
port_b_arbiter.sv
d_mem_subsys.sv
d_mem_checker.sv
d_mem_assert.sv
d_mem_tb.sv

// ==== lsu_access.sv ====
`timescale 1ns/1ps

module lsu_access (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   load_en,
    input  logic                   store_en,
    input  dmem_pkg::byte_addr_t   addr,
    input  dmem_pkg::access_size_e size,
    input  logic                   load_unsigned,
    input  dmem_pkg::data_t        store_data,
    output dmem_pkg::data_t        load_data,
    output logic                   load_valid,
    dmem_port_if.master            mem
);
    import dmem_pkg::*;

    logic [1:0]   byte_off;
    // Load attributes delayed to line up with mem.q
    logic [1:0]   off_q;
    access_size_e size_q;
    logic         unsigned_q;
    // Addressed lanes picked out of the read word
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;

    // ----------------------------------------------------------
    // Request side
    // ----------------------------------------------------------

    // Offset bits beyond the access size are simply ignored
    assign byte_off = addr[1:0];
    assign mem.addr = addr[DMEM_AW+1:2];
    assign mem.wren = store_en;

    // Lane enables and store data replicated into every lane
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                mem.byteena = be_t'(1) << byte_off;
                mem.wdata   = {BE_W{store_data[7:0]}};
            end
            SIZE_HALF: begin
                mem.byteena = byte_off[1] ? be_t'(4'b1100) : be_t'(4'b0011);
                mem.wdata   = {2{store_data[15:0]}};
            end
            default: begin
                mem.byteena = '1;
                mem.wdata   = store_data;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Load return
    // ----------------------------------------------------------

    // One cycle, same as the memory read register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_en;
        end
    end

    // Attributes only move on a load, back-to-back loads each get their own
    always_ff @(posedge clock) begin
        if (load_en) begin
            off_q      <= byte_off;
            size_q     <= size;
            unsigned_q <= load_unsigned;
        end
    end

    // Align addressed lanes down to bit 0
    assign ld_byte = mem.q[8*off_q +: 8];
    assign ld_half = off_q[1] ? mem.q[XLEN-1:16] : mem.q[15:0];

    // Sign fill is forced to zero for unsigned loads
    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data = {{(XLEN-8){ld_byte[7] & ~unsigned_q}}, ld_byte};
            SIZE_HALF: load_data = {{(XLEN-16){ld_half[15] & ~unsigned_q}}, ld_half};
            default:   load_data = mem.q;
        endcase
    end

endmodule

// ==== port_b_arbiter.sv ====
`timescale 1ns/1ps

module port_b_arbiter (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 host_en,
    input  logic                 host_wren,
    input  dmem_pkg::word_addr_t host_addr,
    input  dmem_pkg::data_t      host_wdata,
    input  dmem_pkg::be_t        host_byteena,
    input  dmem_pkg::word_addr_t fill_addr,
    input  dmem_pkg::data_t      fill_data,
    input  logic                 fill_wren,
    output logic                 hold,
    output dmem_pkg::data_t      host_rdata,
    output logic                 host_rvalid,
    dmem_port_if.master          mem
);
    import dmem_pkg::*;

    // Host has fixed priority, the fill engine waits
    assign hold = host_en;

    // ----------------------------------------------------------
    // Port b mux
    // ----------------------------------------------------------
    always_comb begin
        if (host_en) begin
            mem.addr    = host_addr;
            mem.wdata   = host_wdata;
            mem.byteena = host_byteena;
            mem.wren    = host_wren;
        end else begin
            // Fill always writes whole words
            mem.addr    = fill_addr;
            mem.wdata   = fill_data;
            mem.byteena = {BE_W{1'b1}};
            mem.wren    = fill_wren;
        end
    end

    // Only host reads produce a valid
    // Idle cycles of the fill side also read port b, those are ignored
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_en & ~host_wren;
        end
    end

    assign host_rdata = mem.q;

endmodule
